//--- lsu_pkg.sv
package lsu_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int BYTE_LANES = XLEN / 8;
    localparam int LANE_OFS_W = $clog2(BYTE_LANES);

    // Depth of the memory pipeline
    localparam int STAGES = 3;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [BYTE_LANES-1:0] byte_en_t;

    // Return address register, x1
    localparam reg_addr_t LINK_REG = 5'd1;

    ////////////////////////////////////////
    // Codes
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        op_none,
        op_alu,
        op_load,
        op_store
    } mem_op_e;

    // funct3 of loads and stores
    typedef enum logic [2:0] {
        w_byte  = 3'd0,
        w_half  = 3'd1,
        w_word  = 3'd2,
        w_ubyte = 3'd4,
        w_uhalf = 3'd5
    } mem_width_e;

    // Value 3 (flush) is not issued from here
    typedef enum logic [1:0] {
        cmd_idle  = 2'd0,
        cmd_read  = 2'd1,
        cmd_write = 2'd2
    } dcache_cmd_e;

    typedef enum logic [2:0] {
        fwd_reg,
        fwd_ex,
        fwd_mem1,
        fwd_mem2,
        fwd_mem3,
        fwd_wb,
        fwd_written
    } fwd_sel_e;

endpackage

//--- store_format.sv
`timescale 1ns/10ps

module store_format (
    input  logic                 ex_valid,
    input  lsu_pkg::mem_op_e     ex_op,
    input  lsu_pkg::mem_width_e  ex_width,
    input  lsu_pkg::xlen_t       ex_result,
    input  lsu_pkg::xlen_t       ex_store_data,
    output lsu_pkg::dcache_cmd_e dcache_cmd,
    output lsu_pkg::xlen_t       dcache_addr,
    output lsu_pkg::byte_en_t    dcache_byte_en,
    output lsu_pkg::xlen_t       dcache_wdata
);

    logic [lsu_pkg::LANE_OFS_W-1:0] offset;
    logic                           is_load;
    logic                           is_store;

    assign offset   = ex_result[lsu_pkg::LANE_OFS_W-1:0];
    assign is_load  = ex_valid && (ex_op == lsu_pkg::op_load);
    assign is_store = ex_valid && (ex_op == lsu_pkg::op_store);

    always_comb
    begin
        if (is_load)
            dcache_cmd = lsu_pkg::cmd_read;
        else if (is_store)
            dcache_cmd = lsu_pkg::cmd_write;
        else
            dcache_cmd = lsu_pkg::cmd_idle;
    end

    // Word aligned address to the cache
    assign dcache_addr = {ex_result[lsu_pkg::XLEN-1:lsu_pkg::LANE_OFS_W],
                          {lsu_pkg::LANE_OFS_W{1'b0}}};

    ////////////////////////////////////////
    // Byte enables
    ////////////////////////////////////////

    always_comb
    begin
        dcache_byte_en = '0;
        if (is_store)
        begin
            case (ex_width)
                lsu_pkg::w_word:
                    dcache_byte_en = 4'b1111;
                lsu_pkg::w_half:
                begin
                    case (offset)
                        2'd0:    dcache_byte_en = 4'b0011;
                        2'd1:    dcache_byte_en = 4'b0110;
                        2'd2:    dcache_byte_en = 4'b1100;
                        default: dcache_byte_en = 4'b0000; // straddles the word
                    endcase
                end
                lsu_pkg::w_byte:
                    dcache_byte_en = 4'b0001 << offset;
                default:
                    dcache_byte_en = '0;
            endcase
        end
    end

    // Move store data up to its lane
    assign dcache_wdata = ex_store_data << {offset, 3'b000};

endmodule

//--- mem_stage_pipe.sv
`timescale 1ns/10ps

module mem_stage_pipe (
    input  logic                CLK,
    input  logic                rst_n,
    input  logic                advance,
    input  logic                ex_valid,
    input  lsu_pkg::mem_op_e    ex_op,
    input  lsu_pkg::mem_width_e ex_width,
    input  lsu_pkg::xlen_t      ex_result,
    input  lsu_pkg::reg_addr_t  ex_rd,
    output lsu_pkg::xlen_t      mem1_result,
    output lsu_pkg::xlen_t      mem2_result,
    output lsu_pkg::xlen_t      mem3_result,
    output logic                mem3_valid,
    output lsu_pkg::mem_op_e    mem3_op,
    output lsu_pkg::mem_width_e mem3_width,
    output lsu_pkg::reg_addr_t  mem3_rd
);

    // Index 0 is mem1, index 2 is mem3
    logic                stg_valid  [0:2];
    lsu_pkg::mem_op_e    stg_op     [0:2];
    lsu_pkg::mem_width_e stg_width  [0:2];
    lsu_pkg::xlen_t      stg_result [0:2];
    lsu_pkg::reg_addr_t  stg_rd     [0:2];

    ////////////////////////////////////////
    // Control state
    ////////////////////////////////////////

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < $size(stg_valid); i++)
            begin
                stg_valid[i] <= 1'b0;
                stg_op[i]    <= lsu_pkg::op_none;
            end
        end
        else if (advance)
        begin
            stg_valid[0] <= ex_valid;
            stg_op[0]    <= ex_valid ? ex_op : lsu_pkg::op_none;
            for (int i = 1; i < $size(stg_valid); i++)
            begin
                stg_valid[i] <= stg_valid[i-1];
                stg_op[i]    <= stg_op[i-1];
            end
        end
    end

    ////////////////////////////////////////
    // Payload
    ////////////////////////////////////////

    always_ff @(posedge CLK)
    begin
        if (advance)
        begin
            stg_width[0]  <= ex_width;
            stg_result[0] <= ex_result;
            stg_rd[0]     <= ex_rd;
            for (int i = 1; i < $size(stg_result); i++)
            begin
                stg_width[i]  <= stg_width[i-1];
                stg_result[i] <= stg_result[i-1];
                stg_rd[i]     <= stg_rd[i-1];
            end
        end
    end

    assign mem1_result = stg_result[0];
    assign mem2_result = stg_result[1];
    assign mem3_result = stg_result[2];

    // mem3 is the writeback position
    assign mem3_valid = stg_valid[2];
    assign mem3_op    = stg_op[2];
    assign mem3_width = stg_width[2];
    assign mem3_rd    = stg_rd[2];

endmodule

//--- writeback_unit.sv
`timescale 1ns/10ps

module writeback_unit (
    input  logic                CLK,
    input  logic                rst_n,
    input  logic                advance,
    input  logic                mem3_valid,
    input  lsu_pkg::mem_op_e    mem3_op,
    input  lsu_pkg::mem_width_e mem3_width,
    input  lsu_pkg::xlen_t      mem3_result,
    input  lsu_pkg::reg_addr_t  mem3_rd,
    input  lsu_pkg::xlen_t      dcache_rdata,
    output logic                wb_valid,
    output lsu_pkg::reg_addr_t  wb_rd,
    output lsu_pkg::xlen_t      wb_data,
    output lsu_pkg::xlen_t      written_back,
    output lsu_pkg::xlen_t      link_addr
);

    logic [lsu_pkg::LANE_OFS_W-1:0] offset;
    lsu_pkg::xlen_t                 shifted;
    logic [7:0]                     lane_byte;
    logic [15:0]                    lane_half;
    logic                           half_fits;

    assign offset    = mem3_result[lsu_pkg::LANE_OFS_W-1:0];
    assign shifted   = dcache_rdata >> {offset, 3'b000};
    assign lane_byte = shifted[7:0];
    assign lane_half = shifted[15:0];
    // Halfword at offset 3 crosses the word
    assign half_fits = (offset != 2'd3);

    ////////////////////////////////////////
    // Load alignment and extension
    ////////////////////////////////////////

    always_comb
    begin
        if (mem3_op == lsu_pkg::op_load)
        begin
            case (mem3_width)
                lsu_pkg::w_byte:
                    wb_data = {{(lsu_pkg::XLEN-8){lane_byte[7]}}, lane_byte};
                lsu_pkg::w_ubyte:
                    wb_data = {{(lsu_pkg::XLEN-8){1'b0}}, lane_byte};
                lsu_pkg::w_half:
                    wb_data = half_fits ? {{(lsu_pkg::XLEN-16){lane_half[15]}}, lane_half} : '0;
                lsu_pkg::w_uhalf:
                    wb_data = half_fits ? {{(lsu_pkg::XLEN-16){1'b0}}, lane_half} : '0;
                default:
                    wb_data = dcache_rdata;
            endcase
        end
        else
            wb_data = mem3_result;
    end

    assign wb_valid = mem3_valid;
    assign wb_rd    = mem3_rd;

    // Last written value and return address capture
    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            written_back <= '0;
            link_addr    <= '0;
        end
        else if (advance)
        begin
            written_back <= wb_data;
            if (mem3_valid && (mem3_rd == lsu_pkg::LINK_REG) && (mem3_op != lsu_pkg::op_none))
                link_addr <= wb_data;
        end
    end

endmodule

//--- operand_forward.sv
`timescale 1ns/10ps

module operand_forward (
    input  lsu_pkg::fwd_sel_e rs1_sel,
    input  lsu_pkg::fwd_sel_e rs2_sel,
    input  lsu_pkg::xlen_t    rs1_reg,
    input  lsu_pkg::xlen_t    rs2_reg,
    input  lsu_pkg::xlen_t    ex_result,
    input  lsu_pkg::xlen_t    mem1_result,
    input  lsu_pkg::xlen_t    mem2_result,
    input  lsu_pkg::xlen_t    mem3_result,
    input  lsu_pkg::xlen_t    wb_data,
    input  lsu_pkg::xlen_t    written_back,
    output lsu_pkg::xlen_t    rs1_operand,
    output lsu_pkg::xlen_t    rs2_operand
);

    ////////////////////////////////////////
    // Operand selectors
    ////////////////////////////////////////

    always_comb
    begin
        case (rs1_sel)
            lsu_pkg::fwd_reg:     rs1_operand = rs1_reg;
            lsu_pkg::fwd_ex:      rs1_operand = ex_result;
            lsu_pkg::fwd_mem1:    rs1_operand = mem1_result;
            lsu_pkg::fwd_mem2:    rs1_operand = mem2_result;
            // mem3 holds the address for a load
            lsu_pkg::fwd_mem3:    rs1_operand = mem3_result;
            lsu_pkg::fwd_wb:      rs1_operand = wb_data;
            lsu_pkg::fwd_written: rs1_operand = written_back;
            default:              rs1_operand = '0;
        endcase
    end

    always_comb
    begin
        case (rs2_sel)
            lsu_pkg::fwd_reg:     rs2_operand = rs2_reg;
            lsu_pkg::fwd_ex:      rs2_operand = ex_result;
            lsu_pkg::fwd_mem1:    rs2_operand = mem1_result;
            lsu_pkg::fwd_mem2:    rs2_operand = mem2_result;
            lsu_pkg::fwd_mem3:    rs2_operand = mem3_result;
            lsu_pkg::fwd_wb:      rs2_operand = wb_data;
            lsu_pkg::fwd_written: rs2_operand = written_back;
            default:              rs2_operand = '0;
        endcase
    end

endmodule

//--- mem_pipe_top.sv
`timescale 1ns/10ps

module mem_pipe_top (
    input  logic                 CLK,
    input  logic                 rst_n,
    input  logic                 ex_valid,
    input  lsu_pkg::mem_op_e     ex_op,
    input  lsu_pkg::mem_width_e  ex_width,
    input  lsu_pkg::xlen_t       ex_result,
    input  lsu_pkg::xlen_t       ex_store_data,
    input  lsu_pkg::reg_addr_t   ex_rd,
    input  logic                 dcache_ready,
    input  lsu_pkg::xlen_t       dcache_rdata,
    input  lsu_pkg::fwd_sel_e    rs1_sel,
    input  lsu_pkg::fwd_sel_e    rs2_sel,
    input  lsu_pkg::xlen_t       rs1_reg,
    input  lsu_pkg::xlen_t       rs2_reg,
    output logic                 stall,
    output lsu_pkg::dcache_cmd_e dcache_cmd,
    output lsu_pkg::xlen_t       dcache_addr,
    output lsu_pkg::byte_en_t    dcache_byte_en,
    output lsu_pkg::xlen_t       dcache_wdata,
    output logic                 wb_valid,
    output lsu_pkg::reg_addr_t   wb_rd,
    output lsu_pkg::xlen_t       wb_data,
    output lsu_pkg::xlen_t       link_addr,
    output lsu_pkg::xlen_t       rs1_operand,
    output lsu_pkg::xlen_t       rs2_operand
);

    logic                advance;
    lsu_pkg::xlen_t      mem1_result;
    lsu_pkg::xlen_t      mem2_result;
    lsu_pkg::xlen_t      mem3_result;
    logic                mem3_valid;
    lsu_pkg::mem_op_e    mem3_op;
    lsu_pkg::mem_width_e mem3_width;
    lsu_pkg::reg_addr_t  mem3_rd;
    lsu_pkg::xlen_t      written_back;

    // Whole pipe freezes while the cache is busy
    assign advance = dcache_ready;
    assign stall   = !dcache_ready;

    store_format u_store_format (
        .ex_valid       (ex_valid),
        .ex_op          (ex_op),
        .ex_width       (ex_width),
        .ex_result      (ex_result),
        .ex_store_data  (ex_store_data),
        .dcache_cmd     (dcache_cmd),
        .dcache_addr    (dcache_addr),
        .dcache_byte_en (dcache_byte_en),
        .dcache_wdata   (dcache_wdata)
    );

    mem_stage_pipe u_mem_stage_pipe (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .advance     (advance),
        .ex_valid    (ex_valid),
        .ex_op       (ex_op),
        .ex_width    (ex_width),
        .ex_result   (ex_result),
        .ex_rd       (ex_rd),
        .mem1_result (mem1_result),
        .mem2_result (mem2_result),
        .mem3_result (mem3_result),
        .mem3_valid  (mem3_valid),
        .mem3_op     (mem3_op),
        .mem3_width  (mem3_width),
        .mem3_rd     (mem3_rd)
    );

    writeback_unit u_writeback_unit (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .advance      (advance),
        .mem3_valid   (mem3_valid),
        .mem3_op      (mem3_op),
        .mem3_width   (mem3_width),
        .mem3_result  (mem3_result),
        .mem3_rd      (mem3_rd),
        .dcache_rdata (dcache_rdata),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .written_back (written_back),
        .link_addr    (link_addr)
    );

    operand_forward u_operand_forward (
        .rs1_sel      (rs1_sel),
        .rs2_sel      (rs2_sel),
        .rs1_reg      (rs1_reg),
        .rs2_reg      (rs2_reg),
        .ex_result    (ex_result),
        .mem1_result  (mem1_result),
        .mem2_result  (mem2_result),
        .mem3_result  (mem3_result),
        .wb_data      (wb_data),
        .written_back (written_back),
        .rs1_operand  (rs1_operand),
        .rs2_operand  (rs2_operand)
    );

endmodule

//--- tb_mem_pipe.sv
`timescale 1ns/10ps

module tb_mem_pipe;

    localparam int RESET_CYCLES   = 3;
    localparam int ISSUE_CYCLES   = 900;
    localparam int DRAIN_CYCLES   = 97;
    // Three times the full run length
    localparam int TIMEOUT_CYCLES = 3 * (RESET_CYCLES + ISSUE_CYCLES + DRAIN_CYCLES);

    typedef struct packed {
        lsu_pkg::reg_addr_t rd;
        lsu_pkg::mem_op_e   op;
        lsu_pkg::xlen_t     addr;
        lsu_pkg::xlen_t     data;
        int                 acc;
    } item_t;

    logic                 CLK;
    logic                 rst_n;
    logic                 ex_valid;
    lsu_pkg::mem_op_e     ex_op;
    lsu_pkg::mem_width_e  ex_width;
    lsu_pkg::xlen_t       ex_result;
    lsu_pkg::xlen_t       ex_store_data;
    lsu_pkg::reg_addr_t   ex_rd;
    logic                 dcache_ready;
    lsu_pkg::xlen_t       dcache_rdata;
    lsu_pkg::fwd_sel_e    rs1_sel;
    lsu_pkg::fwd_sel_e    rs2_sel;
    lsu_pkg::xlen_t       rs1_reg;
    lsu_pkg::xlen_t       rs2_reg;
    logic                 stall;
    lsu_pkg::dcache_cmd_e dcache_cmd;
    lsu_pkg::xlen_t       dcache_addr;
    lsu_pkg::byte_en_t    dcache_byte_en;
    lsu_pkg::xlen_t       dcache_wdata;
    logic                 wb_valid;
    lsu_pkg::reg_addr_t   wb_rd;
    lsu_pkg::xlen_t       wb_data;
    lsu_pkg::xlen_t       link_addr;
    lsu_pkg::xlen_t       rs1_operand;
    lsu_pkg::xlen_t       rs2_operand;

    // Reference state
    item_t                q[$];
    int                   adv_cnt;
    int                   cycles;
    int                   value_errs;
    int                   other_errs;
    logic                 due_valid;
    lsu_pkg::reg_addr_t   due_rd;
    lsu_pkg::mem_op_e     due_op;
    lsu_pkg::xlen_t       due_addr;
    lsu_pkg::xlen_t       due_data;
    lsu_pkg::xlen_t       exp_mem1;
    lsu_pkg::xlen_t       exp_mem2;
    lsu_pkg::xlen_t       exp_mem3;
    lsu_pkg::xlen_t       exp_written;
    lsu_pkg::xlen_t       exp_link;
    logic                 fwd_ok;
    lsu_pkg::dcache_cmd_e exp_cmd;
    lsu_pkg::xlen_t       exp_addr;
    lsu_pkg::byte_en_t    exp_be;
    lsu_pkg::xlen_t       exp_wdata;
    lsu_pkg::xlen_t       exp_rs1;
    lsu_pkg::xlen_t       exp_rs2;

    mem_pipe_top u_dut (.*);

    ////////////////////////////////////////
    // Reference functions
    ////////////////////////////////////////

    // Cache contents mixed from every address bit
    function automatic lsu_pkg::xlen_t scramble(input lsu_pkg::xlen_t addr);
        return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]} ^ 32'h5A5A_0F0F;
    endfunction

    function automatic lsu_pkg::xlen_t load_value(input lsu_pkg::xlen_t word,
                                                  input lsu_pkg::mem_width_e width,
                                                  input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        case (off)
            2'd0:    h = word[15:0];
            2'd1:    h = word[23:8];
            2'd2:    h = word[31:16];
            default: h = 16'h0000;
        endcase
        case (width)
            lsu_pkg::w_byte:  return {{24{b[7]}}, b};
            lsu_pkg::w_ubyte: return {24'h0, b};
            lsu_pkg::w_half:  return (off == 2'd3) ? 32'h0 : {{16{h[15]}}, h};
            lsu_pkg::w_uhalf: return (off == 2'd3) ? 32'h0 : {16'h0, h};
            default:          return word;
        endcase
    endfunction

    function automatic lsu_pkg::byte_en_t store_lanes(input logic valid,
                                                      input lsu_pkg::mem_op_e op,
                                                      input lsu_pkg::mem_width_e width,
                                                      input logic [1:0] off);
        if (!valid || op != lsu_pkg::op_store)
            return 4'h0;
        case (width)
            lsu_pkg::w_word: return 4'hF;
            lsu_pkg::w_half: return (off == 2'd3) ? 4'h0 : 4'(4'h3 << off);
            lsu_pkg::w_byte: return 4'(4'h1 << off);
            default:         return 4'h0;
        endcase
    endfunction

    function automatic lsu_pkg::xlen_t pick_source(input lsu_pkg::fwd_sel_e sel,
                                                   input lsu_pkg::xlen_t reg_val,
                                                   input lsu_pkg::xlen_t ex_val,
                                                   input lsu_pkg::xlen_t m1,
                                                   input lsu_pkg::xlen_t m2,
                                                   input lsu_pkg::xlen_t m3,
                                                   input lsu_pkg::xlen_t wb,
                                                   input lsu_pkg::xlen_t wr);
        case (sel)
            lsu_pkg::fwd_reg:     return reg_val;
            lsu_pkg::fwd_ex:      return ex_val;
            lsu_pkg::fwd_mem1:    return m1;
            lsu_pkg::fwd_mem2:    return m2;
            lsu_pkg::fwd_mem3:    return m3;
            lsu_pkg::fwd_wb:      return wb;
            default:              return wr;
        endcase
    endfunction

    function automatic void report_mismatch(input string name, input lsu_pkg::xlen_t got,
                                            input lsu_pkg::xlen_t exp);
        value_errs++;
        $display("FAILED %s: got %h, expected %h", name, got, exp);
    endfunction

    always_comb
    begin
        exp_cmd = lsu_pkg::cmd_idle;
        if (ex_valid && ex_op == lsu_pkg::op_load)
            exp_cmd = lsu_pkg::cmd_read;
        else if (ex_valid && ex_op == lsu_pkg::op_store)
            exp_cmd = lsu_pkg::cmd_write;
        exp_addr  = ex_result & 32'hFFFF_FFFC;
        exp_be    = store_lanes(ex_valid, ex_op, ex_width, ex_result[1:0]);
        exp_wdata = ex_store_data << (8 * ex_result[1:0]);
        exp_rs1   = pick_source(rs1_sel, rs1_reg, ex_result, exp_mem1, exp_mem2, exp_mem3,
                                due_data, exp_written);
        exp_rs2   = pick_source(rs2_sel, rs2_reg, ex_result, exp_mem1, exp_mem2, exp_mem3,
                                due_data, exp_written);
    end

    ////////////////////////////////////////
    // Reference queue
    ////////////////////////////////////////

    always @(posedge CLK or negedge rst_n)
    begin
        item_t it;
        if (!rst_n)
        begin
            q.delete();
            adv_cnt = 0;
            due_valid   <= 1'b0;
            due_rd      <= '0;
            due_op      <= lsu_pkg::op_none;
            due_addr    <= '0;
            due_data    <= '0;
            exp_mem1    <= '0;
            exp_mem2    <= '0;
            exp_mem3    <= '0;
            exp_written <= '0;
            exp_link    <= '0;
            fwd_ok      <= 1'b0;
        end
        else if (dcache_ready)
        begin
            // Head in writeback leaves on this edge
            if (due_valid)
            begin
                if (due_rd == lsu_pkg::LINK_REG)
                    exp_link <= due_data;
                void'(q.pop_front());
            end
            exp_written <= due_data;
            if (ex_valid)
            begin
                it.rd   = ex_rd;
                it.op   = ex_op;
                it.addr = ex_result & 32'hFFFF_FFFC;
                it.data = (ex_op == lsu_pkg::op_load) ?
                          load_value(scramble(it.addr), ex_width, ex_result[1:0]) : ex_result;
                it.acc  = adv_cnt;
                q.push_back(it);
            end
            exp_mem3 <= exp_mem2;
            exp_mem2 <= exp_mem1;
            exp_mem1 <= ex_result;
            adv_cnt = adv_cnt + 1;
            // Mem3 is reached two advancing edges after acceptance
            if (q.size() > 0 && adv_cnt - q[0].acc == lsu_pkg::STAGES)
            begin
                due_valid <= 1'b1;
                due_rd    <= q[0].rd;
                due_op    <= q[0].op;
                due_addr  <= q[0].addr;
                due_data  <= q[0].data;
            end
            else
            begin
                due_valid <= 1'b0;
                due_op    <= lsu_pkg::op_none;
                due_data  <= exp_mem2;
            end
            if (adv_cnt > lsu_pkg::STAGES)
                fwd_ok <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    a_cmd: assert property (@(posedge CLK) disable iff (!rst_n) dcache_cmd == exp_cmd)
        else report_mismatch("dcache_cmd", 32'($sampled(dcache_cmd)), 32'($sampled(exp_cmd)));
    a_addr: assert property (@(posedge CLK) disable iff (!rst_n) dcache_addr == exp_addr)
        else report_mismatch("dcache_addr", $sampled(dcache_addr), $sampled(exp_addr));
    a_be: assert property (@(posedge CLK) disable iff (!rst_n) dcache_byte_en == exp_be)
        else report_mismatch("dcache_byte_en", 32'($sampled(dcache_byte_en)),
                             32'($sampled(exp_be)));
    a_wdata: assert property (@(posedge CLK) disable iff (!rst_n) dcache_wdata == exp_wdata)
        else report_mismatch("dcache_wdata", $sampled(dcache_wdata), $sampled(exp_wdata));
    a_stall: assert property (@(posedge CLK) disable iff (!rst_n) stall == !dcache_ready)
        else report_mismatch("stall", 32'($sampled(stall)), 32'(!$sampled(dcache_ready)));
    a_wb_valid: assert property (@(posedge CLK) disable iff (!rst_n) wb_valid == due_valid)
        else report_mismatch("wb_valid", 32'($sampled(wb_valid)), 32'($sampled(due_valid)));
    a_wb_rd: assert property (@(posedge CLK) disable iff (!rst_n) due_valid |-> wb_rd == due_rd)
        else report_mismatch("wb_rd", 32'($sampled(wb_rd)), 32'($sampled(due_rd)));
    a_wb_data: assert property (@(posedge CLK) disable iff (!rst_n)
                                (due_valid || fwd_ok) |-> wb_data == due_data)
        else report_mismatch("wb_data", $sampled(wb_data), $sampled(due_data));
    a_rs1: assert property (@(posedge CLK) disable iff (!rst_n) fwd_ok |-> rs1_operand == exp_rs1)
        else report_mismatch("rs1_operand", $sampled(rs1_operand), $sampled(exp_rs1));
    a_rs2: assert property (@(posedge CLK) disable iff (!rst_n) fwd_ok |-> rs2_operand == exp_rs2)
        else report_mismatch("rs2_operand", $sampled(rs2_operand), $sampled(exp_rs2));
    a_link: assert property (@(posedge CLK) disable iff (!rst_n) link_addr == exp_link)
        else report_mismatch("link_addr", $sampled(link_addr), $sampled(exp_link));

    ////////////////////////////////////////
    // Clock, stimulus and watchdog
    ////////////////////////////////////////

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    always @(posedge CLK)
    begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic drive_cycle(input bit allow_issue);
        int n;
        @(negedge CLK);
        // Ready low about a quarter of the time
        dcache_ready  = ($urandom_range(0, 3) != 0);
        ex_valid      = allow_issue && ($urandom_range(0, 1) == 1);
        ex_op         = ex_valid ? lsu_pkg::mem_op_e'($urandom_range(1, 3)) : lsu_pkg::op_none;
        n             = $urandom_range(0, 4);
        if (ex_op == lsu_pkg::op_store)
            n = n % 3;
        ex_width      = lsu_pkg::mem_width_e'((n < 3) ? n : n + 1);
        ex_result     = $urandom;
        ex_store_data = $urandom;
        ex_rd         = ($urandom_range(0, 3) == 0) ? lsu_pkg::LINK_REG :
                        lsu_pkg::reg_addr_t'($urandom_range(0, 31));
        rs1_sel       = lsu_pkg::fwd_sel_e'($urandom_range(0, 6));
        rs2_sel       = lsu_pkg::fwd_sel_e'($urandom_range(0, 6));
        rs1_reg       = $urandom;
        rs2_reg       = $urandom;
        // Cache model answers the load sitting in writeback
        if (due_valid && due_op == lsu_pkg::op_load)
            dcache_rdata = scramble(due_addr);
        else
            dcache_rdata = $urandom;
    endtask

    initial
    begin
        void'($urandom(88397));
        cycles        = 0;
        value_errs    = 0;
        other_errs    = 0;
        rst_n         = 1'b0;
        ex_valid      = 1'b0;
        ex_op         = lsu_pkg::op_none;
        ex_width      = lsu_pkg::w_word;
        ex_result     = '0;
        ex_store_data = '0;
        ex_rd         = '0;
        dcache_ready  = 1'b1;
        dcache_rdata  = '0;
        rs1_sel       = lsu_pkg::fwd_reg;
        rs2_sel       = lsu_pkg::fwd_reg;
        rs1_reg       = '0;
        rs2_reg       = '0;
        repeat (RESET_CYCLES) @(negedge CLK);
        rst_n = 1'b1;

        repeat (ISSUE_CYCLES) drive_cycle(1'b1);
        for (int i = 0; i < DRAIN_CYCLES && q.size() != 0; i++)
            drive_cycle(1'b0);
        drive_cycle(1'b0);
        if (q.size() != 0)
        begin
            other_errs++;
            $display("Pipeline did not drain, %0d issued items never reached writeback", q.size());
        end

        $display("Check totals: %0d value mismatches, %0d other errors", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

//--- sim.f
lsu_pkg.sv
store_format.sv
mem_stage_pipe.sv
writeback_unit.sv
operand_forward.sv
mem_pipe_top.sv
tb_mem_pipe.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sim.f --top-module tb_mem_pipe -o tb_mem_pipe
./obj_dir/tb_mem_pipe | tee sim.log

if grep -q "Regression passed" sim.log; then
    exit 0
else
    exit 1
fi
